// ==== app_core.sv ====
/*
  Application core. Turns key codes into ASCII characters for the UART
  transmitter, one pending byte at a time, and drives the LED bank from
  received bytes and the count of characters sent.
*/
`timescale 1ns/1ps
`default_nettype none
`include "board_cfg.svh"

module app_core (
  input  logic                 clk,
  input  logic                 sys_rst,
  input  logic                 key_valid,
  output logic                 key_ready,
  input  board_pkg::key_code_t key_code,
  output logic                 tx_valid,
  input  logic                 tx_ready,
  output logic [7:0]           tx_byte,
  input  logic                 rx_valid,
  input  logic [7:0]           rx_byte,
  output logic [`NUM_LEDS-1:0] leds
);

  // keypad legend, first character is key code 0
  localparam logic [127:0] KEY_TABLE = "123A456B789C*0#D";

  logic key_xfer;
  logic tx_xfer;

  function automatic logic [7:0] key_ascii(input board_pkg::key_code_t code);
    return KEY_TABLE[8 * (15 - int'(code)) +: 8];
  endfunction

  // one byte of buffering, scanner stalls while it is full
  assign key_ready = !tx_valid;
  assign key_xfer  = key_valid && key_ready;
  assign tx_xfer   = tx_valid && tx_ready;

  always_ff @(posedge clk) begin
    if (key_xfer) tx_byte <= key_ascii(key_code);
  end

  always_ff @(posedge clk or posedge sys_rst) begin
    if (sys_rst) begin
      tx_valid <= 1'b0;
    end else if (key_xfer) begin
      tx_valid <= 1'b1;
    end else if (tx_xfer) begin
      tx_valid <= 1'b0;
    end
  end

  // low byte shows last rx byte, high byte counts sent characters
  always_ff @(posedge clk or posedge sys_rst) begin
    if (sys_rst) begin
      leds <= '0;
    end else begin
      if (rx_valid) leds[7:0] <= rx_byte;
      if (tx_xfer) leds[`NUM_LEDS-1:8] <= leds[`NUM_LEDS-1:8] + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== board_assert.sv ====
/*
  Concurrent checks on board_top internals: keypad handshake and the serial
  line during reset. Attached to every board_top by the bind below.
*/
`timescale 1ns/1ps
`default_nettype none

module board_assert (
  input logic                 clk,
  input logic                 sys_rst,
  input logic                 key_valid,
  input logic                 key_ready,
  input board_pkg::key_code_t key_code,
  input logic                 uart_tx
);

  // offered code holds until the core takes it
  a_code_stable: assert property (@(posedge clk) disable iff (sys_rst)
    key_valid && !key_ready |=> $stable(key_code))
    else $error("key_code changed while offered and not accepted");

  // serial line idles high through reset
  a_tx_idle_in_reset: assert property (@(posedge clk) sys_rst |-> uart_tx)
    else $error("uart_tx low while sys_rst is active");

  // one transfer per offer
  a_single_transfer: assert property (@(posedge clk) disable iff (sys_rst)
    key_valid && key_ready |=> !key_valid)
    else $error("key_valid still high after a key transfer");

endmodule

bind board_top board_assert u_assert (
  .clk       (clk),
  .sys_rst   (sys_rst),
  .key_valid (key_valid),
  .key_ready (key_ready),
  .key_code  (key_code),
  .uart_tx   (uart_tx)
);

`default_nettype wire

// ==== board_cfg.svh ====
/*
  Build-time constants for the keypad / UART board subsystem.
  Include this header in any module that needs timing or width values.
*/
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// clock cycles per uart bit
`define CLKS_PER_BIT 8

// stable row samples needed to accept a press or release
`define DEBOUNCE_CYCLES 16

// cycles of internal reset after board reset releases
`define RESET_CYCLES 32

// cycles each keypad column stays driven low
`define SCAN_DWELL 4

// led bank width
`define NUM_LEDS 16

`endif

// ==== board_pkg.sv ====
/*
  Shared types for the board subsystem: key codes and FSM state encodings.
  Referenced by scoped name from the scanner, the UART blocks and the top level.
*/
`default_nettype none

package board_pkg;

  // key index, row * 4 + column
  typedef logic [3:0] key_code_t;

  // keypad scanner FSM
  typedef enum logic [1:0] {
    st_scan,
    // same key must stay low for a full debounce window
    st_confirm,
    // code held on key_code until accepted
    st_offer,
    // all rows high for a debounce window before rescanning
    st_wait_release
  } scan_state_t;

  // uart FSM, same encoding for transmitter and receiver
  typedef enum logic [1:0] {
    uart_idle,
    uart_start,
    uart_data,
    uart_stop
  } uart_state_t;

endpackage

`default_nettype wire

// ==== board_top.sv ====
/*
  Board top level. Conditions the board reset and ties the keypad, UART pins
  and LED bank to the application blocks.
*/
`timescale 1ns/1ps
`default_nettype none
`include "board_cfg.svh"

module board_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [3:0]           kpad_row,
  output logic [3:0]           kpad_col,
  input  logic                 uart_rx,
  output logic                 uart_tx,
  output logic [`NUM_LEDS-1:0] leds
);

  logic                 sys_rst;
  logic                 key_valid;
  logic                 key_ready;
  board_pkg::key_code_t key_code;
  logic                 tx_valid;
  logic                 tx_ready;
  logic [7:0]           tx_byte;
  logic                 rx_valid;
  logic [7:0]           rx_byte;

  reset_stretch u_reset (
    .clk     (clk),
    .rst_n   (rst_n),
    .sys_rst (sys_rst)
  );

  keypad_scanner u_scanner (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .kpad_row  (kpad_row),
    .kpad_col  (kpad_col),
    .key_valid (key_valid),
    .key_ready (key_ready),
    .key_code  (key_code)
  );

  app_core u_core (
    .clk (clk), .sys_rst (sys_rst),
    .key_valid (key_valid), .key_ready (key_ready), .key_code (key_code),
    .tx_valid (tx_valid), .tx_ready (tx_ready), .tx_byte (tx_byte),
    .rx_valid (rx_valid), .rx_byte (rx_byte),
    .leds (leds)
  );

  uart_tx u_uart_tx (
    .clk (clk), .sys_rst (sys_rst),
    .tx_valid (tx_valid), .tx_ready (tx_ready), .tx_byte (tx_byte),
    .tx_line (uart_tx)
  );

  uart_rx u_uart_rx (
    .clk (clk), .sys_rst (sys_rst),
    .rx_line (uart_rx), .rx_valid (rx_valid), .rx_byte (rx_byte)
  );

endmodule

`default_nettype wire

// ==== keypad_scanner.sv ====
/*
  4x4 matrix keypad scanner. Walks a low level across the columns, samples the
  rows through a synchronizer, debounces one key and offers its code with
  valid/ready. One code per press; a full release is needed before the next.
*/
`timescale 1ns/1ps
`default_nettype none
`include "board_cfg.svh"

module keypad_scanner (
  input  logic                 clk,
  input  logic                 sys_rst,
  input  logic [3:0]           kpad_row,
  output logic [3:0]           kpad_col,
  output logic                 key_valid,
  input  logic                 key_ready,
  output board_pkg::key_code_t key_code
);

  localparam int DWW = $clog2(`SCAN_DWELL + 1);
  localparam int DBW = $clog2(`DEBOUNCE_CYCLES + 1);

  board_pkg::scan_state_t state, state_next;
  board_pkg::key_code_t   code, code_next;

  logic [1:0]     col, col_next;
  logic [DWW-1:0] dwell;
  logic [DBW-1:0] deb_cnt, deb_next;
  logic [3:0]     row_s1, row_s2;
  logic           dwell_end;
  logic           any_low;
  logic [1:0]     row_hit;

  // rows are asynchronous to clk
  always_ff @(posedge clk or posedge sys_rst) begin
    if (sys_rst) begin
      row_s1 <= 4'hf;
      row_s2 <= 4'hf;
    end else begin
      row_s1 <= kpad_row;
      row_s2 <= row_s1;
    end
  end

  // free-running dwell timer, column steps only on its last cycle
  assign dwell_end = (dwell == DWW'(`SCAN_DWELL - 1));

  // first low row wins, row 0 has priority
  always_comb begin
    any_low = ~&row_s2;
    row_hit = 2'd3;
    for (int r = 3; r >= 0; r--) begin
      if (!row_s2[r]) row_hit = 2'(r);
    end
  end

  always_comb begin
    state_next = state;
    col_next   = col;
    deb_next   = deb_cnt;
    code_next  = code;
    case (state)
      board_pkg::st_scan: begin
        if (dwell_end) begin
          if (any_low) begin
            // stay on this column while confirming
            code_next  = {row_hit, col};
            deb_next   = '0;
            state_next = board_pkg::st_confirm;
          end else begin
            col_next = col + 1'b1;
          end
        end
      end
      board_pkg::st_confirm: begin
        if (dwell_end) begin
          if (!row_s2[code[3:2]]) begin
            deb_next = deb_cnt + 1'b1;
            if (deb_cnt == DBW'(`DEBOUNCE_CYCLES - 1)) begin
              deb_next   = '0;
              state_next = board_pkg::st_offer;
            end
          end else begin
            // bounce or short press, resume scanning
            col_next   = col + 1'b1;
            state_next = board_pkg::st_scan;
          end
        end
      end
      board_pkg::st_offer: begin
        if (key_ready) begin
          deb_next   = '0;
          state_next = board_pkg::st_wait_release;
        end
      end
      board_pkg::st_wait_release: begin
        if (dwell_end) begin
          if (!any_low) begin
            deb_next = deb_cnt + 1'b1;
            if (deb_cnt == DBW'(`DEBOUNCE_CYCLES - 1)) begin
              deb_next   = '0;
              col_next   = col + 1'b1;
              state_next = board_pkg::st_scan;
            end
          end else begin
            // any key still down restarts the window
            deb_next = '0;
          end
        end
      end
      default: state_next = board_pkg::st_scan;
    endcase
  end

  always_ff @(posedge clk or posedge sys_rst) begin
    if (sys_rst) begin
      state    <= board_pkg::st_scan;
      col      <= 2'd0;
      dwell    <= '0;
      deb_cnt  <= '0;
      code     <= '0;
      kpad_col <= 4'hf;
    end else begin
      state   <= state_next;
      col     <= col_next;
      dwell   <= dwell_end ? '0 : dwell + 1'b1;
      deb_cnt <= deb_next;
      code    <= code_next;
      // all columns low while waiting, so any held key shows on a row
      if (state_next == board_pkg::st_wait_release) begin
        kpad_col <= 4'h0;
      end else begin
        kpad_col <= ~(4'b0001 << col_next);
      end
    end
  end

  // code only changes in scan, so it is stable during offer
  assign key_valid = (state == board_pkg::st_offer);
  assign key_code  = code;

endmodule

`default_nettype wire

// ==== reset_stretch.sv ====
/*
  Board reset conditioner. Asserts sys_rst as soon as rst_n drops and keeps
  it high for a fixed number of clock edges after rst_n returns high.
*/
`timescale 1ns/1ps
`default_nettype none
`include "board_cfg.svh"

module reset_stretch (
  input  logic clk,
  input  logic rst_n,
  output logic sys_rst
);

  // wide enough to hold the full reset length
  localparam int CW = $clog2(`RESET_CYCLES + 1);

  logic [CW-1:0] cnt;

  // counter reloads while the board reset is held
  // sys_rst falls on the edge where the count reaches zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt     <= CW'(`RESET_CYCLES);
      sys_rst <= 1'b1;
    end else if (cnt != '0) begin
      cnt     <= cnt - 1'b1;
      // last step of the count releases reset
      sys_rst <= (cnt != CW'(1));
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
board_pkg.sv
reset_stretch.sv
keypad_scanner.sv
uart_tx.sv
uart_rx.sv
app_core.sv
board_top.sv
board_assert.sv
tb_board_top.sv

// ==== tb_board_top.sv ====
/*
  Testbench for board_top. Models the keypad matrix and both UART lines,
  presses keys and sends bytes, then checks frames and LEDs against a reference.
*/
`timescale 1ns/1ps
`default_nettype none
`include "board_cfg.svh"

module tb_board_top;

  // 16 presses of about 250 cycles plus rx and back-pressure tests and margin
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int FRAME_WAIT     = 400;
  localparam int RELEASE_WAIT   = (`DEBOUNCE_CYCLES + 2) * `SCAN_DWELL;

  logic                 clk;
  logic                 rst_n;
  logic [3:0]           kpad_row;
  logic [3:0]           kpad_col;
  logic                 uart_rx;
  logic                 uart_tx;
  logic [`NUM_LEDS-1:0] leds;

  // one key held at a time
  logic                 key_down;
  board_pkg::key_code_t key_sel;

  logic [7:0] exp_q[$];
  logic [7:0] rx_last;
  int         frames_seen;
  int         errors;
  int         cycles;
  int         tests_run;
  int         tests_failed;
  int         test_start_errors;
  string      cur_test;

  board_top u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .kpad_row (kpad_row),
    .kpad_col (kpad_col),
    .uart_rx  (uart_rx),
    .uart_tx  (uart_tx),
    .leds     (leds)
  );

  always #2 clk = ~clk;

  // pressed key pulls its row low while its column is driven low
  always_comb begin
    kpad_row = 4'hf;
    if (key_down && !kpad_col[key_sel[1:0]]) kpad_row[key_sel[3:2]] = 1'b0;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  // key code indexes the legend string
  function automatic logic [7:0] key_to_ascii(input board_pkg::key_code_t k);
    string legend;
    legend = "123A456B789C*0#D";
    return legend[k];
  endfunction

  task automatic check_char(input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("mismatch in %s: expected %h, actual %h", cur_test, exp, act);
      errors++;
    end
  endtask

  task automatic check_leds(input logic [`NUM_LEDS-1:0] exp, input logic [`NUM_LEDS-1:0] act);
    if (act !== exp) begin
      $display("mismatch in %s: expected %h, actual %h", cur_test, exp, act);
      errors++;
    end
  endtask

  task automatic check_idle(input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch in %s: expected %b, actual %b", cur_test, exp, act);
      errors++;
    end
  endtask

  // decodes uart_tx frames mid-bit and compares them in order
  always begin : serial_monitor
    logic [7:0] b;
    @(posedge clk);
    if (rst_n && uart_tx === 1'b0) begin
      repeat (`CLKS_PER_BIT / 2) @(posedge clk);
      for (int i = 0; i < 8; i++) begin
        repeat (`CLKS_PER_BIT) @(posedge clk);
        b[i] = uart_tx;
      end
      repeat (`CLKS_PER_BIT) @(posedge clk);
      if (uart_tx !== 1'b1) begin
        $display("error in %s: stop bit low on uart_tx", cur_test);
        errors++;
      end else if (exp_q.size() == 0) begin
        $display("error in %s: unexpected frame %h on uart_tx", cur_test, b);
        errors++;
      end else begin
        check_char(exp_q.pop_front(), b);
      end
      frames_seen++;
    end
  end

  task automatic set_key(input logic down, input board_pkg::key_code_t k);
    @(posedge clk);
    #1;
    key_down = down;
    key_sel  = k;
  endtask

  task automatic wait_frames(input int n);
    int cnt;
    cnt = 0;
    while (frames_seen < n && cnt < FRAME_WAIT) begin
      @(posedge clk);
      cnt++;
    end
    if (frames_seen < n) begin
      $display("error in %s: no frame on uart_tx within %0d cycles", cur_test, FRAME_WAIT);
      errors++;
    end
  endtask

  task automatic wait_line_low();
    int cnt;
    cnt = 0;
    while (uart_tx !== 1'b0 && cnt < FRAME_WAIT) begin
      @(posedge clk);
      cnt++;
    end
    if (uart_tx !== 1'b0) begin
      $display("error in %s: uart_tx never started a frame", cur_test);
      errors++;
    end
  endtask

  // hold until the character arrives, then let the release window run out
  task automatic press_and_release(input board_pkg::key_code_t k);
    int target;
    target = frames_seen + 1;
    exp_q.push_back(key_to_ascii(k));
    set_key(1'b1, k);
    wait_frames(target);
    set_key(1'b0, k);
    repeat (RELEASE_WAIT) @(posedge clk);
  endtask

  // 8N1 frame sent LSB first
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    @(posedge clk);
    #1;
    for (int i = 0; i < 10; i++) begin
      uart_rx = frame[i];
      repeat (`CLKS_PER_BIT) @(posedge clk);
      #1;
    end
  endtask

  task automatic start_test(input string name);
    cur_test          = name;
    test_start_errors = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_start_errors) begin
      $display("test %s: passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", cur_test, errors - test_start_errors);
    end
  endtask

  initial begin : stimulus
    board_pkg::key_code_t order[16];
    board_pkg::key_code_t tmp;
    logic [7:0]           b;
    int                   j;
    int                   target;
    clk      = 1'b0;
    rst_n    = 1'b0;
    key_down = 1'b0;
    key_sel  = '0;
    uart_rx  = 1'b1;
    rx_last  = 8'h00;
    void'($urandom(32'h799b));
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_test("reset_idle");
    for (int n = 1; n <= `RESET_CYCLES + 8; n++) begin
      @(posedge clk);
      check_idle(1'b1, uart_tx);
      // columns stay inactive until the stretched reset ends
      if (n <= `RESET_CYCLES) check_idle(1'b1, &kpad_col);
    end
    check_leds('0, leds);
    end_test();

    // shuffled press order
    start_test("all_keys");
    for (int i = 0; i < 16; i++) order[i] = 4'(i);
    for (int i = 15; i > 0; i--) begin
      j        = $urandom % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    foreach (order[i]) press_and_release(order[i]);
    check_leds({8'd16, 8'h00}, leds);
    end_test();

    // shorter than one debounce window of dwell samples
    start_test("short_press");
    set_key(1'b1, 4'd6);
    repeat (`DEBOUNCE_CYCLES) @(posedge clk);
    set_key(1'b0, 4'd6);
    repeat (200) @(posedge clk);
    check_leds({8'd16, 8'h00}, leds);
    end_test();

    start_test("uart_rx_bytes");
    repeat (6) begin
      b = 8'($urandom);
      send_byte(b);
      repeat (2) @(posedge clk);
      check_leds({8'd16, b}, leds);
      rx_last = b;
    end
    end_test();

    start_test("back_pressure");
    target = frames_seen + 2;
    exp_q.push_back(key_to_ascii(4'd5));
    exp_q.push_back(key_to_ascii(4'd14));
    set_key(1'b1, 4'd5);
    wait_line_low();
    set_key(1'b0, 4'd5);
    // press again just past the release window while frame one is on the line
    repeat ((`DEBOUNCE_CYCLES + 1) * `SCAN_DWELL + 2) @(posedge clk);
    set_key(1'b1, 4'd14);
    wait_frames(target);
    set_key(1'b0, 4'd14);
    repeat (RELEASE_WAIT) @(posedge clk);
    check_leds({8'd18, rx_last}, leds);
    end_test();

    if (exp_q.size() != 0) begin
      $display("error: %0d expected characters never arrived on uart_tx", exp_q.size());
      errors++;
    end
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
/*
  8N1 UART receiver. Finds the falling start edge, samples each bit in the
  middle of its period and pulses rx_valid for one cycle on a good stop bit.
  Frames with a low stop bit are dropped.
*/
`timescale 1ns/1ps
`default_nettype none
`include "board_cfg.svh"

module uart_rx (
  input  logic       clk,
  input  logic       sys_rst,
  input  logic       rx_line,
  output logic       rx_valid,
  output logic [7:0] rx_byte
);

  localparam int BW = $clog2(`CLKS_PER_BIT);

  board_pkg::uart_state_t state;

  logic [BW-1:0] baud;
  logic [2:0]    bit_idx;
  logic [7:0]    shift;
  logic          rx_s1, rx_s2;
  logic          baud_end;
  logic          half_end;

  assign baud_end = (baud == BW'(`CLKS_PER_BIT - 1));
  assign half_end = (baud == BW'(`CLKS_PER_BIT / 2 - 1));

  // serial line synchronizer, idles high
  always_ff @(posedge clk or posedge sys_rst) begin
    if (sys_rst) begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
    end else begin
      rx_s1 <= rx_line;
      rx_s2 <= rx_s1;
    end
  end

  // data bits arrive LSB first, shift in from the top
  always_ff @(posedge clk) begin
    if (state == board_pkg::uart_data && baud_end) shift <= {rx_s2, shift[7:1]};
    if (state == board_pkg::uart_stop && baud_end && rx_s2) rx_byte <= shift;
  end

  always_ff @(posedge clk or posedge sys_rst) begin
    if (sys_rst) begin
      state    <= board_pkg::uart_idle;
      baud     <= '0;
      bit_idx  <= 3'd0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        board_pkg::uart_idle: begin
          if (!rx_s2) begin
            state <= board_pkg::uart_start;
            baud  <= '0;
          end
        end
        board_pkg::uart_start: begin
          // half a bit in, the start bit must still be low
          if (half_end) begin
            baud <= '0;
            if (!rx_s2) begin
              state   <= board_pkg::uart_data;
              bit_idx <= 3'd0;
            end else begin
              state <= board_pkg::uart_idle;
            end
          end else begin
            baud <= baud + 1'b1;
          end
        end
        board_pkg::uart_data: begin
          // counter now lands mid-bit
          if (baud_end) begin
            baud    <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= board_pkg::uart_stop;
          end else begin
            baud <= baud + 1'b1;
          end
        end
        board_pkg::uart_stop: begin
          if (baud_end) begin
            baud     <= '0;
            state    <= board_pkg::uart_idle;
            // bad stop bit drops the frame
            rx_valid <= rx_s2;
          end else begin
            baud <= baud + 1'b1;
          end
        end
        default: state <= board_pkg::uart_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
/*
  8N1 UART transmitter. Accepts one byte per valid/ready transfer while idle
  and sends start, eight data bits LSB first, then stop.
*/
`timescale 1ns/1ps
`default_nettype none
`include "board_cfg.svh"

module uart_tx (
  input  logic       clk,
  input  logic       sys_rst,
  input  logic       tx_valid,
  output logic       tx_ready,
  input  logic [7:0] tx_byte,
  output logic       tx_line
);

  localparam int BW = $clog2(`CLKS_PER_BIT);

  board_pkg::uart_state_t state;

  logic [BW-1:0] baud;
  logic [2:0]    bit_idx;
  logic [7:0]    data_q;
  logic          baud_end;

  assign baud_end = (baud == BW'(`CLKS_PER_BIT - 1));
  assign tx_ready = (state == board_pkg::uart_idle);

  // byte captured on the transfer edge
  always_ff @(posedge clk) begin
    if (tx_valid && tx_ready) data_q <= tx_byte;
  end

  always_ff @(posedge clk or posedge sys_rst) begin
    if (sys_rst) begin
      state   <= board_pkg::uart_idle;
      baud    <= '0;
      bit_idx <= 3'd0;
      tx_line <= 1'b1;
    end else begin
      case (state)
        board_pkg::uart_idle: begin
          if (tx_valid) begin
            // start bit begins right after the transfer
            state   <= board_pkg::uart_start;
            baud    <= '0;
            tx_line <= 1'b0;
          end
        end
        board_pkg::uart_start: begin
          if (baud_end) begin
            state   <= board_pkg::uart_data;
            baud    <= '0;
            bit_idx <= 3'd0;
            tx_line <= data_q[0];
          end else begin
            baud <= baud + 1'b1;
          end
        end
        board_pkg::uart_data: begin
          if (baud_end) begin
            baud <= '0;
            if (bit_idx == 3'd7) begin
              state   <= board_pkg::uart_stop;
              tx_line <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              tx_line <= data_q[bit_idx + 3'd1];
            end
          end else begin
            baud <= baud + 1'b1;
          end
        end
        board_pkg::uart_stop: begin
          // full stop bit before ready again
          if (baud_end) begin
            state <= board_pkg::uart_idle;
            baud  <= '0;
          end else begin
            baud <= baud + 1'b1;
          end
        end
        default: state <= board_pkg::uart_idle;
      endcase
    end
  end

endmodule

`default_nettype wire
